//--- hdl/oramDefs.svh
//--------------------
// Tree geometry and DRAM widths are fixed per build
// DDR_DATA_WIDTH must be a whole multiple of BED_WIDTH
//--------------------
`ifndef ORAM_DEFS_SVH
`define ORAM_DEFS_SVH

// Tree geometry
`define ORAM_NUM_BUCKETS 16
// DRAM words between two bucket addresses
`define ORAM_BUCKET_WORDS 4

// DRAM command address width
`define DDR_ADDR_WIDTH 16
// One full header word
`define DDR_DATA_WIDTH 128
// Write-data flit toward DRAM
`define BED_WIDTH 32
// Flits per header word
`define BED_PER_WORD (`DDR_DATA_WIDTH / `BED_WIDTH)

// Header fields, IV at the bottom
`define HDR_IV_WIDTH 32
`define HDR_VALID_BITS 8
// Zero fill above the valid bits
`define HDR_PAD_WIDTH (`DDR_DATA_WIDTH - `HDR_VALID_BITS - `HDR_IV_WIDTH)

// IV written into every fresh bucket
`define HDR_INIT_IV 32'h0000_0001

`endif

//--- hdl/oramPkg.sv
//--------------------
// Shared enums for the DRAM back end
// Command encoding is one bit, write or read only
//--------------------
package oramPkg;

	// --------------------
	// DRAM command encoding
	// --------------------
	// Write is the all-zero code
	typedef enum logic {
		cmdWrite = 1'b0,
		cmdRead  = 1'b1
	} dramCommand_t;

	// --------------------
	// DRAM port owner
	// --------------------
	// Initializer owns the port out of reset
	typedef enum logic {
		ownInit  = 1'b0,
		ownFront = 1'b1
	} portOwner_t;

endpackage

//--- hdl/bucketHeaderInit.sv
//--------------------
// Writes one fresh header per bucket after DDR3 calibration
// Command and header streams run on their own handshakes
// initDone is sticky until reset
//--------------------
`include "oramDefs.svh"

module bucketHeaderInit (
	input  logic                         Clock,
	input  logic                         reset,

	// Command stream toward DRAM
	output logic [`DDR_ADDR_WIDTH-1:0]   cmdAddress,
	output oramPkg::dramCommand_t        cmd,
	output logic                         cmdValid,
	input  logic                         cmdReady,

	// Wide header stream toward the shifter
	output logic [`DDR_DATA_WIDTH-1:0]   hdrWord,
	output logic                         hdrValid,
	input  logic                         hdrReady,

	// Both streams complete
	output logic                         initDone
);

	// --------------------
	// Constants
	// --------------------
	localparam int countWidth = $clog2(`ORAM_NUM_BUCKETS + 1);
	localparam int addrWidth  = `DDR_ADDR_WIDTH;

	// Count that ends each stream
	localparam logic [countWidth-1:0] bucketTotal = countWidth'(`ORAM_NUM_BUCKETS);
	// Address step between buckets
	localparam logic [addrWidth-1:0]  addrStep    = addrWidth'(`ORAM_BUCKET_WORDS);
	localparam logic [`HDR_IV_WIDTH-1:0] initIv   = `HDR_INIT_IV;

	// --------------------
	// Signals
	// --------------------
	logic [countWidth-1:0] cmdCount;
	logic [countWidth-1:0] cmdCountNext;
	logic [countWidth-1:0] hdrCount;
	logic [countWidth-1:0] hdrCountNext;
	logic                  cmdFire;
	logic                  hdrFire;
	logic                  cmdDone;
	logic                  hdrDone;

	// --------------------
	// Command stream
	// --------------------
	// Every init command is a write
	assign cmd          = oramPkg::cmdWrite;
	assign cmdFire      = cmdValid & cmdReady;
	assign cmdCountNext = cmdCount + countWidth'(cmdFire);
	assign cmdDone      = (cmdCount == bucketTotal);

	always_ff @(posedge Clock) begin
		if (reset) begin
			cmdAddress <= '0;
			cmdCount   <= '0;
			cmdValid   <= 1'b0;
		end else begin
			// Next bucket base on each accept
			if (cmdFire) begin
				cmdAddress <= cmdAddress + addrStep;
				cmdCount   <= cmdCountNext;
			end
			// Valid drops once the last bucket goes out
			cmdValid <= (cmdCountNext != bucketTotal);
		end
	end

	// --------------------
	// Header stream
	// --------------------
	// Fixed header, zero pad, cleared valid bits, IV lowest
	assign hdrWord = {{`HDR_PAD_WIDTH{1'b0}}, {`HDR_VALID_BITS{1'b0}}, initIv};

	assign hdrFire      = hdrValid & hdrReady;
	assign hdrCountNext = hdrCount + countWidth'(hdrFire);
	assign hdrDone      = (hdrCount == bucketTotal);

	always_ff @(posedge Clock) begin
		if (reset) begin
			hdrCount <= '0;
			hdrValid <= 1'b0;
		end else begin
			if (hdrFire)
				hdrCount <= hdrCountNext;
			// Same identical word for every bucket
			hdrValid <= (hdrCountNext != bucketTotal);
		end
	end

	// --------------------
	// Completion
	// --------------------
	// Set once both counts hit the total, held until reset
	always_ff @(posedge Clock) begin
		if (reset)
			initDone <= 1'b0;
		else if (cmdDone && hdrDone)
			initDone <= 1'b1;
	end

endmodule

//--- hdl/headerDownShifter.sv
//--------------------
// Splits a wide header word into flits, lowest slice first
// Only the case of flits narrower than the word is built
//--------------------
`include "oramDefs.svh"

module headerDownShifter (
	input  logic                         Clock,
	input  logic                         reset,

	// Wide word in
	input  logic [`DDR_DATA_WIDTH-1:0]   inWord,
	input  logic                         inValid,
	output logic                         inReady,

	// Flits out
	output logic [`BED_WIDTH-1:0]        outData,
	output logic                         outValid,
	input  logic                         outReady,

	// A flit is still held
	output logic                         busy
);

	// --------------------
	// Constants
	// --------------------
	localparam int indexWidth = $clog2(`BED_PER_WORD);
	localparam logic [indexWidth-1:0] lastIndex = indexWidth'(`BED_PER_WORD - 1);

	// --------------------
	// Signals
	// --------------------
	logic [`DDR_DATA_WIDTH-1:0] shiftReg;
	logic [indexWidth-1:0]      flitIndex;
	logic                       full;
	logic                       lastFlit;
	logic                       inFire;
	logic                       outFire;

	// Bottom slice is the current flit
	assign outData  = shiftReg[`BED_WIDTH-1:0];
	assign outValid = full;
	assign busy     = full;

	assign lastFlit = (flitIndex == lastIndex);
	assign outFire  = full & outReady;
	// Reload when empty, or as the last flit leaves
	assign inReady  = ~full | (outReady & lastFlit);
	assign inFire   = inValid & inReady;

	// Fill state and flit position
	always_ff @(posedge Clock) begin
		if (reset) begin
			full      <= 1'b0;
			flitIndex <= '0;
		end else if (inFire) begin
			full      <= 1'b1;
			flitIndex <= '0;
		end else if (outFire) begin
			// Empty after the last slice
			full      <= ~lastFlit;
			flitIndex <= lastFlit ? '0 : flitIndex + indexWidth'(1);
		end
	end

	// Payload, shifts down one flit per handshake
	always_ff @(posedge Clock) begin
		if (inFire)
			shiftReg <= inWord;
		else if (outFire)
			shiftReg <= shiftReg >> `BED_WIDTH;
	end

endmodule

//--- hdl/dramPortMux.sv
//--------------------
// Initializer owns the DRAM port until its last flit leaves
// Hand-over to the front end is one way until reset
//--------------------
`include "oramDefs.svh"

module dramPortMux (
	input  logic                         Clock,
	input  logic                         reset,

	// Initializer side
	input  logic                         initDone,
	input  logic                         initBusy,
	input  logic [`DDR_ADDR_WIDTH-1:0]   initCmdAddress,
	input  oramPkg::dramCommand_t        initCmd,
	input  logic                         initCmdValid,
	output logic                         initCmdReady,
	input  logic [`BED_WIDTH-1:0]        initWrData,
	input  logic                         initWrValid,
	output logic                         initWrReady,

	// ORAM front end side
	input  logic [`DDR_ADDR_WIDTH-1:0]   frontCmdAddress,
	input  oramPkg::dramCommand_t        frontCmd,
	input  logic                         frontCmdValid,
	output logic                         frontCmdReady,
	input  logic [`BED_WIDTH-1:0]        frontWrData,
	input  logic                         frontWrValid,
	output logic                         frontWrReady,

	// DRAM side
	output logic [`DDR_ADDR_WIDTH-1:0]   dramCmdAddress,
	output oramPkg::dramCommand_t        dramCmd,
	output logic                         dramCmdValid,
	input  logic                         dramCmdReady,
	output logic [`BED_WIDTH-1:0]        dramWrData,
	output logic                         dramWrValid,
	input  logic                         dramWrReady,

	// Front end may use the port
	output logic                         ready
);

	// --------------------
	// Owner register
	// --------------------
	oramPkg::portOwner_t owner;
	logic                frontOwns;

	// Switch once headers are done and the shifter is drained
	always_ff @(posedge Clock) begin
		if (reset)
			owner <= oramPkg::ownInit;
		else if (owner == oramPkg::ownInit && initDone && !initBusy)
			owner <= oramPkg::ownFront;
	end

	assign frontOwns = (owner == oramPkg::ownFront);
	assign ready     = frontOwns;

	// --------------------
	// Command channel
	// --------------------
	// Pure steering, no added cycles
	assign dramCmdAddress = frontOwns ? frontCmdAddress : initCmdAddress;
	assign dramCmd        = frontOwns ? frontCmd : initCmd;
	assign dramCmdValid   = frontOwns ? frontCmdValid : initCmdValid;
	// DRAM ready goes back to the owner only
	assign initCmdReady   = ~frontOwns & dramCmdReady;
	assign frontCmdReady  = frontOwns & dramCmdReady;

	// --------------------
	// Write-data channel
	// --------------------
	assign dramWrData   = frontOwns ? frontWrData : initWrData;
	assign dramWrValid  = frontOwns ? frontWrValid : initWrValid;
	// Front end held off while headers go out
	assign initWrReady  = ~frontOwns & dramWrReady;
	assign frontWrReady = frontOwns & dramWrReady;

endmodule

//--- hdl/oramDramFront.sv
//--------------------
// DRAM back end start-up, header init then front-end pass-through
//--------------------
`include "oramDefs.svh"

module oramDramFront (
	input  logic                         Clock,
	input  logic                         reset,

	// ORAM front end
	input  logic [`DDR_ADDR_WIDTH-1:0]   frontCmdAddress,
	input  oramPkg::dramCommand_t        frontCmd,
	input  logic                         frontCmdValid,
	output logic                         frontCmdReady,
	input  logic [`BED_WIDTH-1:0]        frontWrData,
	input  logic                         frontWrValid,
	output logic                         frontWrReady,

	// DDR3 controller
	output logic [`DDR_ADDR_WIDTH-1:0]   dramCmdAddress,
	output oramPkg::dramCommand_t        dramCmd,
	output logic                         dramCmdValid,
	input  logic                         dramCmdReady,
	output logic [`BED_WIDTH-1:0]        dramWrData,
	output logic                         dramWrValid,
	input  logic                         dramWrReady,

	// Init finished, front end live
	output logic                         ready
);

	// --------------------
	// Internal channels
	// --------------------
	// Initializer commands
	logic [`DDR_ADDR_WIDTH-1:0] initCmdAddress;
	oramPkg::dramCommand_t      initCmd;
	logic                       initCmdValid;
	logic                       initCmdReady;
	// Wide header words
	logic [`DDR_DATA_WIDTH-1:0] hdrWord;
	logic                       hdrValid;
	logic                       hdrReady;
	// Header flits
	logic [`BED_WIDTH-1:0]      initWrData;
	logic                       initWrValid;
	logic                       initWrReady;
	logic                       initDone;
	logic                       initBusy;

	bucketHeaderInit u_headerInit (
		.Clock(Clock), .reset(reset),
		.cmdAddress(initCmdAddress), .cmd(initCmd),
		.cmdValid(initCmdValid), .cmdReady(initCmdReady),
		.hdrWord(hdrWord), .hdrValid(hdrValid), .hdrReady(hdrReady),
		.initDone(initDone)
	);

	headerDownShifter u_shifter (
		.Clock(Clock), .reset(reset),
		.inWord(hdrWord), .inValid(hdrValid), .inReady(hdrReady),
		.outData(initWrData), .outValid(initWrValid), .outReady(initWrReady),
		.busy(initBusy)
	);

	dramPortMux u_mux (
		.Clock(Clock), .reset(reset),
		.initDone(initDone), .initBusy(initBusy),
		.initCmdAddress(initCmdAddress), .initCmd(initCmd),
		.initCmdValid(initCmdValid), .initCmdReady(initCmdReady),
		.initWrData(initWrData), .initWrValid(initWrValid), .initWrReady(initWrReady),
		.frontCmdAddress(frontCmdAddress), .frontCmd(frontCmd),
		.frontCmdValid(frontCmdValid), .frontCmdReady(frontCmdReady),
		.frontWrData(frontWrData), .frontWrValid(frontWrValid),
		.frontWrReady(frontWrReady),
		.dramCmdAddress(dramCmdAddress), .dramCmd(dramCmd),
		.dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.dramWrData(dramWrData), .dramWrValid(dramWrValid), .dramWrReady(dramWrReady),
		.ready(ready)
	);

endmodule

//--- verification/clockGen.sv
//--------------------
// Free-running clock, period 20
// Reset high for three rising edges, released on a falling edge
//--------------------
module clockGen (
	output logic Clock,
	output logic reset
);

	localparam int halfPeriod = 10;

	// Clock toggles forever
	initial begin
		Clock = 1'b0;
		forever #(halfPeriod) Clock = ~Clock;
	end

	// Synchronous reset, active high
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		reset = 1'b0;
	end

endmodule

//--- verification/oramDramFrontTb.sv
//--------------------
// Header init traffic then 64 front-end transfers under random DRAM ready
// Outputs sampled on the rising edge and inputs driven on the falling edge
//--------------------
`include "oramDefs.svh"

module oramDramFrontTb;

	localparam int frontCount = 64;
	localparam int initFlits  = `ORAM_NUM_BUCKETS * `BED_PER_WORD;
	// Eight cycles of 20 time units per expected transfer
	localparam int watchdogLimit = (initFlits + frontCount) * 8 * 20;

	logic                       Clock;
	logic                       reset;
	logic [`DDR_ADDR_WIDTH-1:0] frontCmdAddress;
	oramPkg::dramCommand_t      frontCmd;
	logic                       frontCmdValid;
	logic                       frontCmdReady;
	logic [`BED_WIDTH-1:0]      frontWrData;
	logic                       frontWrValid;
	logic                       frontWrReady;
	logic [`DDR_ADDR_WIDTH-1:0] dramCmdAddress;
	oramPkg::dramCommand_t      dramCmd;
	logic                       dramCmdValid;
	logic                       dramCmdReady;
	logic [`BED_WIDTH-1:0]      dramWrData;
	logic                       dramWrValid;
	logic                       dramWrReady;
	logic                       ready;

	// Front-end stimulus generated once
	logic [`DDR_ADDR_WIDTH-1:0] frontAddrList [0:frontCount-1];
	oramPkg::dramCommand_t      frontCmdList  [0:frontCount-1];
	logic [`BED_WIDTH-1:0]      frontDataList [0:frontCount-1];

	// Progress and error counters
	int mismatchCount = 0;
	int failureCount  = 0;
	int initCmdSeen   = 0;
	int initFlitSeen  = 0;
	int frontCmdSent  = 0;
	int frontWrSent   = 0;
	int frontCmdSeen  = 0;
	int frontWrSeen   = 0;
	int unsigned seedValue;
	logic readySeen = 1'b0;

	// Stall tracking for payload stability
	logic                       cmdStalled = 1'b0;
	logic                       wrStalled  = 1'b0;
	logic [`DDR_ADDR_WIDTH-1:0] heldAddress;
	oramPkg::dramCommand_t      heldCommand;
	logic [`BED_WIDTH-1:0]      heldData;
	logic [`DDR_ADDR_WIDTH-1:0] expectedAddress;

	clockGen u_clockGen (.Clock(Clock), .reset(reset));

	oramDramFront u_dut (
		.Clock(Clock), .reset(reset),
		.frontCmdAddress(frontCmdAddress), .frontCmd(frontCmd),
		.frontCmdValid(frontCmdValid), .frontCmdReady(frontCmdReady),
		.frontWrData(frontWrData), .frontWrValid(frontWrValid),
		.frontWrReady(frontWrReady),
		.dramCmdAddress(dramCmdAddress), .dramCmd(dramCmd),
		.dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.dramWrData(dramWrData), .dramWrValid(dramWrValid), .dramWrReady(dramWrReady),
		.ready(ready)
	);

	// --------------------
	// Reference model
	// --------------------
	// Header holds the IV lowest with cleared valid bits and zero pad above
	function automatic logic [`BED_WIDTH-1:0] headerFlit(input int index);
		logic [`DDR_DATA_WIDTH-1:0] word;
		int slice;
		word = '0;
		word[`HDR_IV_WIDTH-1:0] = `HDR_INIT_IV;
		word[`HDR_IV_WIDTH +: `HDR_VALID_BITS] = '0;
		// Lowest slice goes out first
		slice = index % `BED_PER_WORD;
		return word[slice * `BED_WIDTH +: `BED_WIDTH];
	endfunction

	// --------------------
	// Compare tasks
	// --------------------
	task automatic checkAddress(input string name, input logic [`DDR_ADDR_WIDTH-1:0] expected,
		input logic [`DDR_ADDR_WIDTH-1:0] actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
		end
	endtask

	task automatic checkCommand(input string name, input oramPkg::dramCommand_t expected,
		input oramPkg::dramCommand_t actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic checkFlit(input string name, input logic [`BED_WIDTH-1:0] expected,
		input logic [`BED_WIDTH-1:0] actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
		end
	endtask

	task automatic checkLevel(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("MISMATCH %s expected %b actual %b", name, expected, actual);
		end
	endtask

	// Transfer totals at hand-over
	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			mismatchCount++;
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// --------------------
	// Stimulus and DRAM sink
	// --------------------
	initial begin
		seedValue = 68317;
		// Seed the generator of this process once
		void'($urandom(seedValue));
		for (int i = 0; i < frontCount; i++) begin
			frontAddrList[i] = `DDR_ADDR_WIDTH'($urandom);
			frontCmdList[i]  = oramPkg::dramCommand_t'($urandom % 2);
			frontDataList[i] = `BED_WIDTH'($urandom);
		end
		// Front end requests from time zero on
		frontCmdAddress = frontAddrList[0];
		frontCmd        = frontCmdList[0];
		frontCmdValid   = 1'b1;
		frontWrData     = frontDataList[0];
		frontWrValid    = 1'b1;
		dramCmdReady    = 1'b0;
		dramWrReady     = 1'b0;
		forever begin
			@(negedge Clock);
			// Ready three times out of four
			dramCmdReady = ($urandom % 4) != 0;
			dramWrReady  = ($urandom % 4) != 0;
			// Next item only after a handshake
			frontCmdValid = (frontCmdSent < frontCount);
			if (frontCmdSent < frontCount) begin
				frontCmdAddress = frontAddrList[frontCmdSent];
				frontCmd        = frontCmdList[frontCmdSent];
			end
			frontWrValid = (frontWrSent < frontCount);
			if (frontWrSent < frontCount)
				frontWrData = frontDataList[frontWrSent];
		end
	end

	// --------------------
	// Monitor
	// --------------------
	always @(posedge Clock) begin
		if (reset === 1'b0) begin
			// Payload must hold across a stall
			if (cmdStalled) begin
				checkLevel("command valid held", 1'b1, dramCmdValid);
				checkAddress("command address held", heldAddress, dramCmdAddress);
				checkCommand("command held", heldCommand, dramCmd);
			end
			if (wrStalled) begin
				checkLevel("write valid held", 1'b1, dramWrValid);
				checkFlit("write data held", heldData, dramWrData);
			end
			if (ready === 1'b1) begin
				// Hand-over only after all header traffic
				if (!readySeen) begin
					readySeen = 1'b1;
					checkCount("init command total", `ORAM_NUM_BUCKETS, initCmdSeen);
					checkCount("init flit total", initFlits, initFlitSeen);
				end
				if (dramCmdValid && dramCmdReady) begin
					if (frontCmdSeen < frontCount) begin
						checkAddress($sformatf("front command %0d address", frontCmdSeen),
							frontAddrList[frontCmdSeen], dramCmdAddress);
						checkCommand($sformatf("front command %0d", frontCmdSeen),
							frontCmdList[frontCmdSeen], dramCmd);
					end else begin
						failureCount++;
						$display("Extra DRAM command after the front-end stream ended");
					end
					frontCmdSeen++;
				end
				if (dramWrValid && dramWrReady) begin
					if (frontWrSeen < frontCount)
						checkFlit($sformatf("front flit %0d", frontWrSeen),
							frontDataList[frontWrSeen], dramWrData);
					else begin
						failureCount++;
						$display("Extra DRAM write flit after the front-end stream ended");
					end
					frontWrSeen++;
				end
			end else begin
				if (readySeen)
					checkLevel("ready stays high", 1'b1, ready);
				// Front end locked out during init
				checkLevel("frontCmdReady during init", 1'b0, frontCmdReady);
				checkLevel("frontWrReady during init", 1'b0, frontWrReady);
				if (dramCmdValid && dramCmdReady) begin
					expectedAddress = `DDR_ADDR_WIDTH'(initCmdSeen * `ORAM_BUCKET_WORDS);
					checkAddress($sformatf("init command %0d address", initCmdSeen),
						expectedAddress, dramCmdAddress);
					checkCommand($sformatf("init command %0d", initCmdSeen),
						oramPkg::cmdWrite, dramCmd);
					initCmdSeen++;
				end
				if (dramWrValid && dramWrReady) begin
					checkFlit($sformatf("header flit %0d", initFlitSeen),
						headerFlit(initFlitSeen), dramWrData);
					initFlitSeen++;
				end
			end
			// Front-side handshakes pace the driver
			if (frontCmdValid && frontCmdReady)
				frontCmdSent++;
			if (frontWrValid && frontWrReady)
				frontWrSent++;
			cmdStalled  = dramCmdValid && !dramCmdReady;
			wrStalled   = dramWrValid && !dramWrReady;
			heldAddress = dramCmdAddress;
			heldCommand = dramCmd;
			heldData    = dramWrData;
		end
	end

	// --------------------
	// Run control
	// --------------------
	initial begin
		@(negedge reset);
		#1;
		// Control outputs quiet after reset
		checkLevel("dramCmdValid after reset", 1'b0, dramCmdValid);
		checkLevel("dramWrValid after reset", 1'b0, dramWrValid);
		checkLevel("frontCmdReady after reset", 1'b0, frontCmdReady);
		checkLevel("frontWrReady after reset", 1'b0, frontWrReady);
		checkLevel("ready after reset", 1'b0, ready);
		wait (frontCmdSeen >= frontCount && frontWrSeen >= frontCount);
		// Idle tail catches stray traffic
		repeat (20) @(posedge Clock);
		#1;
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdogLimit);
		failureCount++;
		$display("Timeout: the run did not finish within %0d time units", watchdogLimit);
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+hdl
hdl/oramPkg.sv
hdl/bucketHeaderInit.sv
hdl/headerDownShifter.sv
hdl/dramPortMux.sv
hdl/oramDramFront.sv
verification/clockGen.sv
verification/oramDramFrontTb.sv
